//--- design/read_guard_pkg.sv
// Read guard package: sizes, index width helper, bus, config and status structs
package read_guard_pkg;

  // Default sizes
  localparam int unsigned IdWidth    = 4;
  localparam int unsigned LenWidth   = 8;
  localparam int unsigned CntWidth   = 12;
  localparam int unsigned DefMaxTxns = 8;

  // Index width for a table of n entries, never below one bit
  function automatic int unsigned idx_width(input int unsigned n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  // Status counter holds 0..DefMaxTxns
  localparam int unsigned OpenCntWidth = idx_width(DefMaxTxns) + 1;

  typedef logic [IdWidth-1:0] id_t;

  // Manager side of the read channels
  typedef struct packed {
    logic                ar_valid;
    id_t                 ar_id;
    logic [LenWidth-1:0] ar_len;
    logic                r_ready;
  } rd_req_t;

  // Subordinate side of the read channels
  typedef struct packed {
    logic ar_ready;
    logic r_valid;
    id_t  r_id;
    logic r_last;
  } rd_rsp_t;

  // Software settings
  typedef struct packed {
    logic                enable;
    logic [CntWidth-1:0] budget;
  } guard_cfg_t;

  // Reported state
  typedef struct packed {
    logic [OpenCntWidth-1:0] open_cnt;
    logic                    timeout_seen;
    id_t                     timeout_id;
    logic                    full;
  } guard_status_t;

endpackage

//--- design/rd_txn_table.sv
// Outstanding read table: ID match, lowest free slot search, in-order retirement per ID
`timescale 1ns/1ps

module rd_txn_table import read_guard_pkg::*; #(
  parameter int unsigned MaxRdTxns = DefMaxTxns,
  localparam int unsigned IdxWidth = idx_width(MaxRdTxns)
) (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic                             flush_i,
  input  rd_req_t                          mst_req_i,
  input  rd_rsp_t                          slv_rsp_i,
  output logic [MaxRdTxns-1:0]             entry_valid_o,
  output id_t  [MaxRdTxns-1:0]             entry_id_o,
  output logic                             alloc_en_o,
  output logic [IdxWidth-1:0]              alloc_idx_o,
  output logic [IdxWidth:0]                open_cnt_o,
  output logic                             full_o
);

  logic [MaxRdTxns-1:0]               valid_q;
  id_t  [MaxRdTxns-1:0]               id_q;
  // Position of the entry among open reads of the same ID, 0 is oldest
  logic [MaxRdTxns-1:0][IdxWidth-1:0] seq_q;

  logic                 ar_hs;
  logic                 r_done;
  logic [MaxRdTxns-1:0] id_hit_ar;
  logic [MaxRdTxns-1:0] id_hit_r;
  logic [MaxRdTxns-1:0] retire_vec;
  logic                 retire_hit;
  logic                 have_free;
  logic [IdxWidth-1:0]  free_idx;
  logic [IdxWidth:0]    same_id_cnt;
  logic [IdxWidth:0]    valid_cnt;
  logic [IdxWidth-1:0]  new_seq;
  logic [IdxWidth:0]    open_cnt_q;
  logic                 full_q;

  assign ar_hs  = mst_req_i.ar_valid & slv_rsp_i.ar_ready;
  assign r_done = slv_rsp_i.r_valid & mst_req_i.r_ready & slv_rsp_i.r_last;

  // Per-entry ID compares
  always_comb begin
    for (int i = 0; i < MaxRdTxns; i++) begin
      id_hit_ar[i]  = valid_q[i] && (id_q[i] == mst_req_i.ar_id);
      id_hit_r[i]   = valid_q[i] && (id_q[i] == slv_rsp_i.r_id);
      retire_vec[i] = id_hit_r[i] && (seq_q[i] == '0);
    end
  end

  // Last beat with no matching open read is dropped here
  assign retire_hit = r_done && (|retire_vec);

  // Lowest free slot
  always_comb begin
    have_free = 1'b0;
    free_idx  = '0;
    for (int i = MaxRdTxns - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        have_free = 1'b1;
        free_idx  = IdxWidth'(i);
      end
    end
  end

  // Open reads per ID and in total
  always_comb begin
    same_id_cnt = '0;
    valid_cnt   = '0;
    for (int i = 0; i < MaxRdTxns; i++) begin
      same_id_cnt = same_id_cnt + (IdxWidth + 1)'(id_hit_ar[i]);
      valid_cnt   = valid_cnt + (IdxWidth + 1)'(valid_q[i]);
    end
    // A same-ID retirement in this cycle moves the new read up by one
    if (retire_hit && (slv_rsp_i.r_id == mst_req_i.ar_id)) begin
      same_id_cnt = same_id_cnt - 1'b1;
    end
  end

  assign new_seq     = IdxWidth'(same_id_cnt);
  assign alloc_en_o  = ar_hs && have_free && !flush_i;
  assign alloc_idx_o = free_idx;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      valid_q <= '0;
    end else begin
      for (int i = 0; i < MaxRdTxns; i++) begin
        if (retire_hit && retire_vec[i]) begin
          valid_q[i] <= 1'b0;
        end
      end
      if (alloc_en_o) begin
        valid_q[free_idx] <= 1'b1;
      end
    end
  end

  // Entry payload
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < MaxRdTxns; i++) begin
      if (retire_hit && id_hit_r[i] && !retire_vec[i]) begin
        seq_q[i] <= seq_q[i] - 1'b1;
      end
    end
    if (alloc_en_o) begin
      id_q[free_idx]  <= mst_req_i.ar_id;
      seq_q[free_idx] <= new_seq;
    end
  end

  // Counts trail the table by one edge
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      open_cnt_q <= '0;
      full_q     <= 1'b0;
    end else begin
      open_cnt_q <= valid_cnt;
      full_q     <= &valid_q;
    end
  end

  assign entry_valid_o = valid_q;
  assign entry_id_o    = id_q;
  assign open_cnt_o    = open_cnt_q;
  assign full_o        = full_q;

endmodule

//--- design/rd_budget_timer.sv
// Per-entry age counters and timeout detection against the software budget
`timescale 1ns/1ps

module rd_budget_timer import read_guard_pkg::*; #(
  parameter int unsigned MaxRdTxns = DefMaxTxns,
  localparam int unsigned IdxWidth = idx_width(MaxRdTxns)
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 flush_i,
  input  guard_cfg_t           cfg_i,
  input  logic [MaxRdTxns-1:0] entry_valid_i,
  input  logic                 alloc_en_i,
  input  logic [IdxWidth-1:0]  alloc_idx_i,
  output logic                 timeout_o,
  output logic [IdxWidth-1:0]  timeout_idx_o
);

  logic [MaxRdTxns-1:0][CntWidth-1:0] age_q;
  logic [MaxRdTxns-1:0]               expired;

  // Age starts at zero on the accepting edge
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      age_q <= '0;
    end else begin
      for (int i = 0; i < MaxRdTxns; i++) begin
        if (alloc_en_i && (alloc_idx_i == IdxWidth'(i))) begin
          age_q[i] <= '0;
        end else if (entry_valid_i[i] && (age_q[i] != '1)) begin
          // saturate rather than wrap
          age_q[i] <= age_q[i] + 1'b1;
        end
      end
    end
  end

  // Pulses on the cycle the age reaches the budget
  always_comb begin
    for (int i = 0; i < MaxRdTxns; i++) begin
      expired[i] = cfg_i.enable && entry_valid_i[i] && (age_q[i] == cfg_i.budget);
    end
  end

  // Lowest expired entry wins
  always_comb begin
    timeout_o     = 1'b0;
    timeout_idx_o = '0;
    for (int i = MaxRdTxns - 1; i >= 0; i--) begin
      if (expired[i]) begin
        timeout_o     = 1'b1;
        timeout_idx_o = IdxWidth'(i);
      end
    end
  end

endmodule

//--- design/rd_reset_handler.sv
// Four-phase reset request FSM, interrupt, table flush and sticky timeout record
`timescale 1ns/1ps

module rd_reset_handler import read_guard_pkg::*; (
  input  logic clk_i,
  input  logic rst_i,
  input  logic timeout_i,
  input  id_t  timeout_id_i,
  input  logic reset_clear_i,
  output logic reset_req_o,
  output logic irq_o,
  output logic flush_o,
  output logic timeout_seen_o,
  output id_t  timeout_id_o
);

  typedef enum logic [1:0] {
    StIdle,
    StRequest,
    StWaitRelease
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   seen_q;
  id_t    id_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      StIdle: begin
        if (timeout_i) begin
          state_d = StRequest;
        end
      end
      StRequest: begin
        if (reset_clear_i) begin
          state_d = StWaitRelease;
        end
      end
      StWaitRelease: begin
        // No new request until the clear has dropped
        if (!reset_clear_i) begin
          state_d = StIdle;
        end
      end
      default: state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // First timeout since reset is kept
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      seen_q <= 1'b0;
      id_q   <= '0;
    end else if ((state_q == StIdle) && timeout_i && !seen_q) begin
      seen_q <= 1'b1;
      id_q   <= timeout_id_i;
    end
  end

  assign reset_req_o    = (state_q == StRequest);
  assign irq_o          = (state_q == StRequest);
  // Table empties on the edge that drops the request
  assign flush_o        = (state_q == StRequest) && reset_clear_i;
  assign timeout_seen_o = seen_q;
  assign timeout_id_o   = id_q;

endmodule

//--- design/read_guard.sv
// Read guard top level: table, budget timer, reset handler and status packing
`timescale 1ns/1ps

module read_guard import read_guard_pkg::*; #(
  parameter int unsigned MaxRdTxns = DefMaxTxns,
  localparam int unsigned IdxWidth = idx_width(MaxRdTxns)
) (
  input  logic          clk_i,
  input  logic          rst_i,
  input  guard_cfg_t    cfg_i,
  input  rd_req_t       mst_req_i,
  input  rd_rsp_t       slv_rsp_i,
  input  logic          reset_clear_i,
  output logic          reset_req_o,
  output logic          irq_o,
  output guard_status_t status_o
);

  logic                 flush;
  logic [MaxRdTxns-1:0] entry_valid;
  id_t  [MaxRdTxns-1:0] entry_id;
  logic                 alloc_en;
  logic [IdxWidth-1:0]  alloc_idx;
  logic [IdxWidth:0]    open_cnt;
  logic                 full;
  logic                 timeout;
  logic [IdxWidth-1:0]  timeout_idx;
  id_t                  timeout_entry_id;
  logic                 timeout_seen;
  id_t                  timeout_id;

  rd_txn_table #(
    .MaxRdTxns ( MaxRdTxns )
  ) i_rd_txn_table (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .flush_i       ( flush       ),
    .mst_req_i     ( mst_req_i   ),
    .slv_rsp_i     ( slv_rsp_i   ),
    .entry_valid_o ( entry_valid ),
    .entry_id_o    ( entry_id    ),
    .alloc_en_o    ( alloc_en    ),
    .alloc_idx_o   ( alloc_idx   ),
    .open_cnt_o    ( open_cnt    ),
    .full_o        ( full        )
  );

  rd_budget_timer #(
    .MaxRdTxns ( MaxRdTxns )
  ) i_rd_budget_timer (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .flush_i       ( flush       ),
    .cfg_i         ( cfg_i       ),
    .entry_valid_i ( entry_valid ),
    .alloc_en_i    ( alloc_en    ),
    .alloc_idx_i   ( alloc_idx   ),
    .timeout_o     ( timeout     ),
    .timeout_idx_o ( timeout_idx )
  );

  // ID of the expiring entry for the status record
  assign timeout_entry_id = entry_id[timeout_idx];

  rd_reset_handler i_rd_reset_handler (
    .clk_i          ( clk_i            ),
    .rst_i          ( rst_i            ),
    .timeout_i      ( timeout          ),
    .timeout_id_i   ( timeout_entry_id ),
    .reset_clear_i  ( reset_clear_i    ),
    .reset_req_o    ( reset_req_o      ),
    .irq_o          ( irq_o            ),
    .flush_o        ( flush            ),
    .timeout_seen_o ( timeout_seen     ),
    .timeout_id_o   ( timeout_id       )
  );

  always_comb begin
    status_o.open_cnt     = OpenCntWidth'(open_cnt);
    status_o.timeout_seen = timeout_seen;
    status_o.timeout_id   = timeout_id;
    status_o.full         = full;
  end

endmodule

//--- test/read_guard_checker.sv
// Bus watcher with a reference model of open reads, per-test report and mismatch count
`timescale 1ns/1ps

module read_guard_checker import read_guard_pkg::*; #(
  parameter int unsigned MaxRdTxns = DefMaxTxns
) (
  input  logic          clk_i,
  input  logic          rst_i,
  input  guard_cfg_t    cfg_i,
  input  rd_req_t       mst_req_i,
  input  rd_rsp_t       slv_rsp_i,
  input  logic          reset_clear_i,
  input  logic          reset_req_i,
  input  logic          irq_i,
  input  guard_status_t status_i,
  input  logic          test_done_i,
  input  logic          report_i,
  output int unsigned   errors_o
);

  // Open reads in order of acceptance
  id_t         open_id[$];
  int unsigned open_age[$];

  int unsigned exp_cnt;
  logic        exp_full;
  logic        exp_req;
  // Clear seen, waiting for it to drop
  logic        exp_release;
  logic        exp_seen;
  id_t         exp_id;
  int unsigned errors    = 0;
  int unsigned test_num  = 0;
  int unsigned test_errs = 0;
  int unsigned tests_ok  = 0;

  assign errors_o = errors;

  task automatic compare(input string what, input int unsigned got, input int unsigned exp);
    if (got != exp) begin
      $display("error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  always @(posedge clk_i) begin
    logic        timeout;
    id_t         timeout_id;
    logic        flush;
    int unsigned cnt_now;
    int          hit;
    if (rst_i) begin
      open_id.delete();
      open_age.delete();
      exp_cnt     = 0;
      exp_full    = 1'b0;
      exp_req     = 1'b0;
      exp_release = 1'b0;
      exp_seen    = 1'b0;
      exp_id      = '0;
    end else begin
      compare("reset_req_o", reset_req_i, exp_req);
      compare("irq_o", irq_i, exp_req);
      compare("open_cnt", status_i.open_cnt, exp_cnt);
      compare("full", status_i.full, exp_full);
      compare("timeout_seen", status_i.timeout_seen, exp_seen);
      compare("timeout_id", status_i.timeout_id, exp_id);

      // Oldest read at its budget raises the request
      timeout    = 1'b0;
      timeout_id = '0;
      for (int i = 0; i < open_id.size(); i++) begin
        if (cfg_i.enable && !timeout && open_age[i] == cfg_i.budget) begin
          timeout    = 1'b1;
          timeout_id = open_id[i];
        end
      end
      flush   = exp_req && reset_clear_i;
      cnt_now = open_id.size();

      if (exp_release) begin
        exp_release = reset_clear_i;
      end else if (exp_req) begin
        exp_req     = !reset_clear_i;
        exp_release = reset_clear_i;
      end else if (timeout) begin
        exp_req = 1'b1;
        if (!exp_seen) begin
          exp_seen = 1'b1;
          exp_id   = timeout_id;
        end
      end

      if (flush) begin
        open_id.delete();
        open_age.delete();
        exp_cnt  = 0;
        exp_full = 1'b0;
      end else begin
        // Status shows the table as it stood before this edge
        exp_cnt  = cnt_now;
        exp_full = (cnt_now == MaxRdTxns);
        foreach (open_age[i]) begin
          open_age[i]++;
        end
        if (slv_rsp_i.r_valid && mst_req_i.r_ready && slv_rsp_i.r_last) begin
          hit = -1;
          for (int i = 0; i < open_id.size(); i++) begin
            if (hit < 0 && open_id[i] == slv_rsp_i.r_id) begin
              hit = i;
            end
          end
          if (hit >= 0) begin
            open_id.delete(hit);
            open_age.delete(hit);
          end
        end
        // No room means the read goes unrecorded
        if (mst_req_i.ar_valid && slv_rsp_i.ar_ready && cnt_now < MaxRdTxns) begin
          open_id.push_back(mst_req_i.ar_id);
          open_age.push_back(0);
        end
      end
    end

    if (test_done_i) begin
      test_num++;
      if (test_errs == 0) begin
        tests_ok++;
      end
      $display("test %0d %s, %0d mismatches", test_num, (test_errs == 0) ? "ok" : "bad",
               test_errs);
      test_errs = 0;
    end
    if (report_i) begin
      $display("summary: %0d of %0d tests clean, %0d mismatches", tests_ok, test_num, errors);
    end
  end

endmodule

//--- test/tb_read_guard.sv
// Read guard testbench: clock, reset, stimulus table run in a loop, final verdict
`timescale 1ns/1ps

module tb_read_guard import read_guard_pkg::*; ();

  localparam int unsigned MaxRdTxns = DefMaxTxns;
  localparam int unsigned Budget    = 50;
  localparam int unsigned WaitLimit = 2 * Budget;
  localparam int unsigned NumSteps  = 29;

  typedef enum logic [2:0] {
    ActIssue,
    ActBeats,
    ActIdle,
    ActWaitReq,
    ActClear,
    ActRelease,
    ActEnd
  } act_e;

  // Issue and beats cover IDs id to id+num-1, each read carries len+1 beats
  typedef struct packed {
    act_e                act;
    id_t                 id;
    logic [7:0]          num;
    logic [LenWidth-1:0] len;
  } step_t;

  logic          clk = 1'b0;
  logic          rst;
  guard_cfg_t    cfg;
  rd_req_t       mst_req;
  rd_rsp_t       slv_rsp;
  logic          reset_clear;
  logic          reset_req;
  logic          irq;
  guard_status_t status;
  logic          test_done;
  logic          report;
  int unsigned   errors;
  logic          stuck;
  step_t         steps [NumSteps];

  always #10 clk = ~clk;

  read_guard #(
    .MaxRdTxns ( MaxRdTxns )
  ) uut (
    .clk_i         ( clk         ),
    .rst_i         ( rst         ),
    .cfg_i         ( cfg         ),
    .mst_req_i     ( mst_req     ),
    .slv_rsp_i     ( slv_rsp     ),
    .reset_clear_i ( reset_clear ),
    .reset_req_o   ( reset_req   ),
    .irq_o         ( irq         ),
    .status_o      ( status      )
  );

  read_guard_checker #(
    .MaxRdTxns ( MaxRdTxns )
  ) i_read_guard_checker (
    .clk_i         ( clk         ),
    .rst_i         ( rst         ),
    .cfg_i         ( cfg         ),
    .mst_req_i     ( mst_req     ),
    .slv_rsp_i     ( slv_rsp     ),
    .reset_clear_i ( reset_clear ),
    .reset_req_i   ( reset_req   ),
    .irq_i         ( irq         ),
    .status_i      ( status      ),
    .test_done_i   ( test_done   ),
    .report_i      ( report      ),
    .errors_o      ( errors      )
  );

  task automatic issue_reads(input id_t first, input logic [7:0] num,
                             input logic [LenWidth-1:0] len);
    for (int k = 0; k < int'(num); k++) begin
      mst_req.ar_valid = 1'b1;
      mst_req.ar_id    = first + id_t'(k);
      mst_req.ar_len   = len;
      // Subordinate may hold off acceptance for a cycle
      slv_rsp.ar_ready = 1'b0;
      repeat ($urandom_range(0, 1)) @(negedge clk);
      slv_rsp.ar_ready = 1'b1;
      @(negedge clk);
    end
    mst_req.ar_valid = 1'b0;
    slv_rsp.ar_ready = 1'b0;
  endtask

  task automatic send_beats(input id_t first, input logic [7:0] num,
                            input logic [LenWidth-1:0] len);
    for (int k = 0; k < int'(num); k++) begin
      for (int b = 0; b <= int'(len); b++) begin
        repeat ($urandom_range(0, 2)) @(negedge clk);
        slv_rsp.r_valid = 1'b1;
        slv_rsp.r_id    = first + id_t'(k);
        slv_rsp.r_last  = (b == int'(len));
        mst_req.r_ready = 1'b1;
        @(negedge clk);
        slv_rsp.r_valid = 1'b0;
        slv_rsp.r_last  = 1'b0;
        mst_req.r_ready = 1'b0;
      end
    end
  endtask

  task automatic wait_request();
    int unsigned cycles;
    cycles = 0;
    while (!reset_req && cycles < WaitLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (!reset_req) begin
      $display("timeout: reset request did not rise within %0d cycles", WaitLimit);
      stuck = 1'b1;
    end
  endtask

  // Wait for the request, raise the clear and see the request drop
  task automatic clear_request();
    int unsigned cycles;
    wait_request();
    if (!stuck) begin
      reset_clear = 1'b1;
      cycles = 0;
      while (reset_req && cycles < 4) begin
        @(negedge clk);
        cycles++;
      end
      if (reset_req) begin
        $display("timeout: reset request stayed high after the clear");
        stuck = 1'b1;
      end
    end
  endtask

  initial begin
    void'($urandom(32'h2101a221));
    cfg         = '{enable: 1'b1, budget: CntWidth'(Budget)};
    mst_req     = '0;
    slv_rsp     = '0;
    reset_clear = 1'b0;
    test_done   = 1'b0;
    report      = 1'b0;
    stuck       = 1'b0;
    rst         = 1'b1;
    steps = '{
      // act        id     num                 len
      '{ActIdle,    4'd0,  8'd4,               8'd0},
      '{ActEnd,     4'd0,  8'd0,               8'd0},
      '{ActIssue,   4'd1,  8'd3,               8'd1},
      '{ActIdle,    4'd0,  8'd2,               8'd0},
      '{ActBeats,   4'd1,  8'd3,               8'd1},
      '{ActIdle,    4'd0,  8'd3,               8'd0},
      '{ActEnd,     4'd0,  8'd0,               8'd0},
      '{ActIssue,   4'd9,  8'd1,               8'd0},
      '{ActWaitReq, 4'd0,  8'd0,               8'd0},
      '{ActEnd,     4'd0,  8'd0,               8'd0},
      // Read accepted under the clear expires with no new request
      '{ActClear,   4'd0,  8'd0,               8'd0},
      '{ActIssue,   4'd5,  8'd1,               8'd0},
      '{ActIdle,    4'd0,  8'(Budget + 5),     8'd0},
      '{ActRelease, 4'd0,  8'd0,               8'd0},
      '{ActBeats,   4'd5,  8'd1,               8'd0},
      '{ActIdle,    4'd0,  8'd3,               8'd0},
      '{ActEnd,     4'd0,  8'd0,               8'd0},
      '{ActIssue,   4'd3,  8'd1,               8'd0},
      '{ActIdle,    4'd0,  8'd4,               8'd0},
      '{ActIssue,   4'd3,  8'd1,               8'd0},
      '{ActBeats,   4'd3,  8'd1,               8'd0},
      '{ActClear,   4'd0,  8'd0,               8'd0},
      '{ActRelease, 4'd0,  8'd0,               8'd0},
      '{ActEnd,     4'd0,  8'd0,               8'd0},
      '{ActIssue,   4'd0,  8'(MaxRdTxns + 1),  8'd0},
      '{ActIdle,    4'd0,  8'd2,               8'd0},
      '{ActBeats,   4'd0,  8'(MaxRdTxns + 1),  8'd0},
      '{ActIdle,    4'd0,  8'd3,               8'd0},
      '{ActEnd,     4'd0,  8'd0,               8'd0}
    };
    repeat (8) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < int'(NumSteps) && !stuck; i++) begin
      case (steps[i].act)
        ActIssue:   issue_reads(steps[i].id, steps[i].num, steps[i].len);
        ActBeats:   send_beats(steps[i].id, steps[i].num, steps[i].len);
        ActIdle:    repeat (steps[i].num) @(negedge clk);
        ActWaitReq: wait_request();
        ActClear:   clear_request();
        ActRelease: begin
          reset_clear = 1'b0;
          @(negedge clk);
        end
        default: begin
          test_done = 1'b1;
          @(negedge clk);
          test_done = 1'b0;
        end
      endcase
    end
    report = 1'b1;
    @(negedge clk);
    report = 1'b0;
    if (!stuck && errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- read_guard.f
design/read_guard_pkg.sv
design/rd_txn_table.sv
design/rd_budget_timer.sv
design/rd_reset_handler.sv
design/read_guard.sv
test/read_guard_checker.sv
test/tb_read_guard.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_read_guard
RTL_TOP    := read_guard
FILELIST   := read_guard.f
FLAGS      := --binary --timing -j 0 -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
BUILD_DIR  := obj_dir
SIM        := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the simulator output alone
run: build
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
